/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_fifo_bank
FILELIST   = list.f
LOG        = sim.log
FAIL_MSG   = Something failed
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* fifo_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_apb_regs
   import fifo_pkg::*;
(
   input  wire logic                         clk_i,
   input  wire logic                         rst_i,

   // APB slave
   input  wire logic                         psel_i,
   input  wire logic                         penable_i,
   input  wire logic                         pwrite_i,
   input  wire logic [`FIFO_APB_ADDR_W-1:0]  paddr_i,
   input  wire word_t                        pwdata_i,
   output word_t                             prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,

   // channel status
   input  wire logic [`FIFO_N_CH-1:0]        ch_full_i,
   input  wire logic [`FIFO_N_CH-1:0]        ch_empty_i,
   input  wire level_t [`FIFO_N_CH-1:0]      ch_level_i,

   // push to the channels
   output logic [`FIFO_N_CH-1:0]             push_o,
   output byte_t                             push_data_o
);

   localparam int STRIDE_LSB = $clog2(`FIFO_CH_STRIDE);
   localparam int MAP_BYTES  = `FIFO_N_CH * `FIFO_CH_STRIDE;

   logic    setup;
   logic    access;
   logic    addr_ok;
   ch_idx_t addr_ch;
   logic    dec_ok_q;
   ch_idx_t dec_ch_q;
   logic    ch_full;
   logic    wr_ok;

   assign setup  = psel_i & ~penable_i;
   assign access = psel_i & penable_i;

   // word aligned and inside the channel block
   assign addr_ok = (paddr_i[STRIDE_LSB-1:0] == '0) && (int'(paddr_i) < MAP_BYTES);
   assign addr_ch = ch_idx_t'(paddr_i >> STRIDE_LSB);

   // paddr is stable from setup to access, so decode it one cycle early
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dec_ok_q <= 1'b0;
         dec_ch_q <= '0;
      end else if (setup) begin
         dec_ok_q <= addr_ok;
         dec_ch_q <= addr_ch;
      end
   end

   assign ch_full = ch_full_i[dec_ch_q];
   assign wr_ok   = access & pwrite_i & dec_ok_q & ~ch_full;

   // no wait states
   assign pready_o  = access;
   assign pslverr_o = access & (~dec_ok_q | (pwrite_i & ch_full));

   assign push_data_o = pwdata_i[`FIFO_W_DATA_W-1:0];

   always_comb begin
      push_o           = '0;
      push_o[dec_ch_q] = wr_ok;
   end

   // status word of the addressed channel
   always_comb begin
      prdata_o = '0;
      if (access && !pwrite_i && dec_ok_q) begin
         prdata_o[`FIFO_ADDR_W:0]       = ch_level_i[dec_ch_q];
         prdata_o[`FIFO_STAT_EMPTY_BIT] = ch_empty_i[dec_ch_q];
         prdata_o[`FIFO_STAT_FULL_BIT]  = ch_full;
      end
   end

endmodule

`default_nettype wire

/* fifo_asym_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_asym_ram
   import fifo_pkg::*;
(
   input  wire logic  clk_i,

   // byte write port
   input  wire logic  w_en_i,
   input  wire wptr_t w_addr_i,
   input  wire byte_t w_data_i,

   // word read port
   input  wire logic  r_en_i,
   input  wire rptr_t r_addr_i,
   output word_t      r_data_o
);

   localparam int LANE_W = $clog2(`FIFO_RATIO);
   localparam int ROWS   = 1 << (`FIFO_ADDR_W - LANE_W);

   word_t             mem [ROWS];
   logic [LANE_W-1:0] w_lane;
   rptr_t             w_row;
   lane_en_t          lane_en;
   word_t             r_data_q;

   // low address bits pick the lane, upper bits the row
   assign w_lane = w_addr_i[LANE_W-1:0];
   assign w_row  = w_addr_i[`FIFO_ADDR_W-1:LANE_W];

   always_comb begin
      lane_en         = '0;
      lane_en[w_lane] = w_en_i;
   end

   always_ff @(posedge clk_i) begin
      for (int i = 0; i < `FIFO_RATIO; i++) begin
         if (lane_en[i]) begin
            mem[w_row][i*`FIFO_W_DATA_W +: `FIFO_W_DATA_W] <= w_data_i;
         end
      end
   end

   // whole row out, one cycle after the read enable
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_q <= mem[r_addr_i];
      end
   end

   assign r_data_o = r_data_q;

endmodule

`default_nettype wire

/* fifo_bank_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_bank_props
   import fifo_pkg::*;
(
   input  wire logic    clk_i,
   input  wire logic    rst_i,
   input  wire logic    psel_i,
   input  wire logic    penable_i,
   input  wire logic    pready_o,
   input  wire logic    out_valid_o,
   input  wire word_t   out_data_o,
   input  wire ch_idx_t out_ch_o,
   input  wire logic    out_ready_i
);

   // a stalled word stays put until it is taken
   property stream_hold_p;
      @(posedge clk_i) disable iff (rst_i)
         out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_ch_o);
   endproperty

   property valid_after_reset_p;
      @(posedge clk_i) rst_i |=> !out_valid_o;
   endproperty

   // no wait states
   property pready_access_p;
      @(posedge clk_i) disable iff (rst_i)
         psel_i && penable_i |-> pready_o;
   endproperty

   stream_hold_a: assert property (stream_hold_p)
      else $error("output stream changed while stalled");

   valid_after_reset_a: assert property (valid_after_reset_p)
      else $error("out_valid_o high in the cycle after reset");

   pready_access_a: assert property (pready_access_p)
      else $error("pready_o low in an APB access phase");

endmodule

`default_nettype wire

/* fifo_bank_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_bank_top
   import fifo_pkg::*;
(
   input  wire logic                         clk_i,
   input  wire logic                         rst_i,

   // APB slave
   input  wire logic                         psel_i,
   input  wire logic                         penable_i,
   input  wire logic                         pwrite_i,
   input  wire logic [`FIFO_APB_ADDR_W-1:0]  paddr_i,
   input  wire word_t                        pwdata_i,
   output word_t                             prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,

   // output stream
   output logic                              out_valid_o,
   output word_t                             out_data_o,
   output ch_idx_t                           out_ch_o,
   input  wire logic                         out_ready_i
);

   logic [`FIFO_N_CH-1:0]   push;
   byte_t                   push_data;
   logic [`FIFO_N_CH-1:0]   pop;
   logic [`FIFO_N_CH-1:0]   ch_empty;
   logic [`FIFO_N_CH-1:0]   ch_full;
   level_t [`FIFO_N_CH-1:0] ch_level;
   word_t [`FIFO_N_CH-1:0]  ch_rdata;

   fifo_apb_regs apb_regs_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .ch_full_i   (ch_full),
      .ch_empty_i  (ch_empty),
      .ch_level_i  (ch_level),
      .push_o      (push),
      .push_data_o (push_data)
   );

   // one byte-in, word-out buffer per channel
   for (genvar c = 0; c < `FIFO_N_CH; c++) begin : g_ch
      fifo_sync fifo_sync_inst (
         .clk_i     (clk_i),
         .rst_i     (rst_i),
         .w_en_i    (push[c]),
         .w_data_i  (push_data),
         .w_full_o  (ch_full[c]),
         .r_en_i    (pop[c]),
         .r_data_o  (ch_rdata[c]),
         .r_empty_o (ch_empty[c]),
         .level_o   (ch_level[c])
      );
   end

   fifo_drain_arb drain_arb_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ch_empty_i  (ch_empty),
      .ch_rdata_i  (ch_rdata),
      .pop_o       (pop),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_ch_o    (out_ch_o),
      .out_ready_i (out_ready_i)
   );

endmodule

`default_nettype wire

/* fifo_drain_arb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_drain_arb
   import fifo_pkg::*;
(
   input  wire logic                    clk_i,
   input  wire logic                    rst_i,

   // channel side
   input  wire logic [`FIFO_N_CH-1:0]   ch_empty_i,
   input  wire word_t [`FIFO_N_CH-1:0]  ch_rdata_i,
   output logic [`FIFO_N_CH-1:0]        pop_o,

   // output stream
   output logic                         out_valid_o,
   output word_t                        out_data_o,
   output ch_idx_t                      out_ch_o,
   input  wire logic                    out_ready_i
);

   drain_state_t state_q;
   ch_idx_t      last_q;
   ch_idx_t      pick;
   logic         found;
   word_t        data_q;

   // round-robin search from the channel after the last one served
   always_comb begin
      ch_idx_t cand;
      pick  = last_q;
      found = 1'b0;
      for (int i = 1; i <= `FIFO_N_CH; i++) begin
         cand = ch_idx_t'((int'(last_q) + i) % `FIFO_N_CH);
         if (!found && !ch_empty_i[cand]) begin
            pick  = cand;
            found = 1'b1;
         end
      end
   end

   always_comb begin
      pop_o = '0;
      if (state_q == DR_IDLE) begin
         pop_o[pick] = found;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= DR_IDLE;
         // first search then starts at channel 0
         last_q  <= ch_idx_t'(`FIFO_N_CH - 1);
      end else begin
         case (state_q)
            DR_IDLE: begin
               if (found) begin
                  last_q  <= pick;
                  state_q <= DR_READ;
               end
            end
            DR_READ: begin
               state_q <= DR_HOLD;
            end
            DR_HOLD: begin
               if (out_ready_i) begin
                  state_q <= DR_IDLE;
               end
            end
            default: begin
               state_q <= DR_IDLE;
            end
         endcase
      end
   end

   // word arrives one cycle after the pop
   always_ff @(posedge clk_i) begin
      if (state_q == DR_READ) begin
         data_q <= ch_rdata_i[last_q];
      end
   end

   assign out_valid_o = (state_q == DR_HOLD);
   assign out_data_o  = data_q;
   assign out_ch_o    = last_q;

endmodule

`default_nettype wire

/* fifo_macros.svh */
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// channel count
`define FIFO_N_CH           4

// narrow write side, wide read side
`define FIFO_W_DATA_W       8
`define FIFO_R_DATA_W       32
`define FIFO_RATIO          4

// byte address, 16 bytes per channel
`define FIFO_ADDR_W         4

// APB register map
`define FIFO_APB_ADDR_W     8
`define FIFO_CH_STRIDE      4
`define FIFO_STAT_EMPTY_BIT 8
`define FIFO_STAT_FULL_BIT  9

`endif

/* fifo_pkg.sv */
`default_nettype none
`include "fifo_macros.svh"

package fifo_pkg;

   typedef logic [`FIFO_W_DATA_W-1:0] byte_t;
   typedef logic [`FIFO_R_DATA_W-1:0] word_t;

   typedef logic [$clog2(`FIFO_N_CH)-1:0] ch_idx_t;

   // one extra bit so a full channel can report 16
   typedef logic [`FIFO_ADDR_W:0] level_t;

   // byte address on the write side, word address on the read side
   typedef logic [`FIFO_ADDR_W-1:0] wptr_t;
   typedef logic [`FIFO_ADDR_W-$clog2(`FIFO_RATIO)-1:0] rptr_t;

   typedef logic [`FIFO_RATIO-1:0] lane_en_t;

   typedef enum logic [1:0] {
      DR_IDLE,
      DR_READ,
      DR_HOLD
   } drain_state_t;

endpackage

`default_nettype wire

/* fifo_sync.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_sync
   import fifo_pkg::*;
(
   input  wire logic  clk_i,
   input  wire logic  rst_i,

   // write port, one byte
   input  wire logic  w_en_i,
   input  wire byte_t w_data_i,
   output logic       w_full_o,

   // read port, one word
   input  wire logic  r_en_i,
   output word_t      r_data_o,
   output logic       r_empty_o,

   output level_t     level_o
);

   localparam level_t W_INCR     = level_t'(1);
   localparam level_t R_INCR     = level_t'(`FIFO_RATIO);
   localparam level_t FULL_LIMIT = level_t'((1 << `FIFO_ADDR_W) - 1);

   logic   w_en_int;
   logic   r_en_int;
   wptr_t  w_addr_q;
   rptr_t  r_addr_q;
   level_t level_q;
   level_t level_nxt;
   logic   empty_nxt;
   logic   full_nxt;

   // no write when full, no read when less than a word is stored
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_addr_q <= '0;
         r_addr_q <= '0;
      end else begin
         if (w_en_int) begin
            w_addr_q <= w_addr_q + wptr_t'(1);
         end
         if (r_en_int) begin
            r_addr_q <= r_addr_q + rptr_t'(1);
         end
      end
   end

   // level in bytes
   always_comb begin
      level_nxt = level_q;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   assign empty_nxt = level_nxt < R_INCR;
   assign full_nxt  = level_nxt > FULL_LIMIT;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         r_empty_o <= empty_nxt;
         w_full_o  <= full_nxt;
      end
   end

   assign level_o = level_q;

   fifo_asym_ram ram_inst (
      .clk_i    (clk_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_addr_q),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_addr_q),
      .r_data_o (r_data_o)
   );

endmodule

`default_nettype wire

/* list.f */
+incdir+.
fifo_pkg.sv
fifo_asym_ram.sv
fifo_sync.sv
fifo_apb_regs.sv
fifo_drain_arb.sv
fifo_bank_top.sv
fifo_bank_props.sv
tb_fifo_bank.sv

/* tb_fifo_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module tb_fifo_bank
   import fifo_pkg::*;
();

   typedef logic [`FIFO_APB_ADDR_W-1:0] apb_addr_t;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DLY  = 10;
   localparam int DEPTH      = 1 << `FIFO_ADDR_W;
   localparam int N_RAND     = 64;
   // APB accesses planned over the six tests
   localparam int N_ACCESS   = 4 + 6 + 26 + 12 + (N_RAND + 16 + 4) + 20;
   localparam int TIMEOUT    = 20 * N_ACCESS + 500;
   localparam apb_addr_t BAD_ADDR [4] = '{8'h01, 8'h06, 8'h10, 8'h43};
   localparam int FILL_ORDER [4] = '{1, 3, 0, 2};

   logic      clk, rst, psel, penable, pwrite, pready, pslverr;
   logic      out_valid, out_ready, ready_rand, rr_on, rr_have;
   apb_addr_t paddr;
   word_t     pwdata, prdata, out_data;
   ch_idx_t   out_ch, rr_prev;
   byte_t     ref_q [`FIFO_N_CH][$];
   integer    seed = 32'h3df4;
   int        cycles, errors, mon_errors, checks, tests, xfers;

   fifo_bank_top fifo_bank_top_inst (
      .clk_i (clk), .rst_i (rst), .psel_i (psel), .penable_i (penable),
      .pwrite_i (pwrite), .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
      .pready_o (pready), .pslverr_o (pslverr), .out_valid_o (out_valid),
      .out_data_o (out_data), .out_ch_o (out_ch), .out_ready_i (out_ready)
   );

   bind fifo_bank_top fifo_bank_props props_inst (
      .clk_i (clk_i), .rst_i (rst_i), .psel_i (psel_i), .penable_i (penable_i),
      .pready_o (pready_o), .out_valid_o (out_valid_o), .out_data_o (out_data_o),
      .out_ch_o (out_ch_o), .out_ready_i (out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("run did not finish within %0d cycles", TIMEOUT);
      $display("Something failed");
      $finish;
   end

   // every output transfer is compared with the reference queue of its channel
   always @(negedge clk) begin
      word_t exp_word;
      if (!rst && out_valid && out_ready) begin
         if (ref_q[out_ch].size() < `FIFO_RATIO) begin
            mon_errors++;
            $display("word on channel %0d at %0t was never written", out_ch, $time);
         end else begin
            for (int i = 0; i < `FIFO_RATIO; i++) begin
               exp_word[i*`FIFO_W_DATA_W +: `FIFO_W_DATA_W] = ref_q[out_ch].pop_front();
            end
            assert (out_data == exp_word) else begin
               mon_errors++;
               $display("ERR %0t out_data_o got %h expected %h", $time, out_data, exp_word);
            end
         end
         if (rr_on && rr_have) begin
            assert (out_ch == rr_prev + ch_idx_t'(1)) else begin
               mon_errors++;
               $display("ERR %0t out_ch_o got %0d expected %0d", $time, out_ch,
                        rr_prev + ch_idx_t'(1));
            end
         end
         rr_have = rr_on;
         rr_prev = out_ch;
         xfers++;
      end
   end

   task automatic check_val(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic tick();
      int r;
      @(posedge clk);
      #DRIVE_DLY;
      if (ready_rand) begin
         r = $random(seed);
         out_ready = r[0];
      end
   endtask

   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input byte_t data,
                           output word_t rdata, output logic err);
      tick();
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = word_t'(data);
      tick();
      penable = 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      tick();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic push_byte(input int ch, input byte_t data, output logic err);
      word_t rd;
      apb_xfer(1'b1, apb_addr_t'(ch * `FIFO_CH_STRIDE), data, rd, err);
      if (!err) begin
         ref_q[ch].push_back(data);
      end
   endtask

   // back-pressure may leave a channel full for a while
   task automatic push_until_taken(input int ch);
      logic err;
      int   r;
      do begin
         r = $random(seed);
         push_byte(ch, r[7:0], err);
      end while (err);
   endtask

   task automatic read_status(input int ch, input int lvl, input int empty, input int full);
      word_t rd;
      logic  err;
      apb_xfer(1'b0, apb_addr_t'(ch * `FIFO_CH_STRIDE), 8'h00, rd, err);
      check_val("pslverr_o", int'(err), 0);
      check_val("prdata_o level", int'(rd[`FIFO_ADDR_W:0]), lvl);
      check_val("prdata_o empty", int'(rd[`FIFO_STAT_EMPTY_BIT]), empty);
      check_val("prdata_o full", int'(rd[`FIFO_STAT_FULL_BIT]), full);
   endtask

   task automatic wait_xfers(input int n);
      while (xfers < n) begin
         tick();
      end
   endtask

   function automatic int queued_bytes();
      int n;
      n = 0;
      for (int c = 0; c < `FIFO_N_CH; c++) begin
         n += ref_q[c].size();
      end
      return n;
   endfunction

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s finished, errors so far %0d", tests, name, errors + mon_errors);
   endtask

   initial begin
      word_t rd;
      logic  err;
      int    base;
      int    r;
      rst        = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      out_ready  = 1'b1;
      ready_rand = 1'b0;
      rr_on      = 1'b0;
      rr_have    = 1'b0;
      rr_prev    = '0;
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;

      for (int c = 0; c < `FIFO_N_CH; c++) begin
         read_status(c, 0, 1, 0);
      end
      check_val("out_valid_o", int'(out_valid), 0);
      end_test("reset status");

      for (int i = 0; i < 3; i++) begin
         r = $random(seed);
         push_byte(2, r[7:0], err);
         check_val("pslverr_o", int'(err), 0);
      end
      read_status(2, 3, 1, 0);
      check_val("out_valid_o", int'(out_valid), 0);
      check_val("transfers", xfers, 0);
      push_byte(2, 8'hc3, err);
      wait_xfers(1);
      read_status(2, 0, 1, 0);
      end_test("single word");

      // drain holds the first word outside the FIFO
      out_ready = 1'b0;
      base = xfers;
      for (int i = 0; i < `FIFO_RATIO + DEPTH; i++) begin
         r = $random(seed);
         push_byte(1, r[7:0], err);
         check_val("pslverr_o", int'(err), 0);
      end
      read_status(1, DEPTH, 0, 1);
      push_byte(1, 8'h5a, err);
      check_val("pslverr_o", int'(err), 1);
      read_status(1, DEPTH, 0, 1);
      check_val("transfers", xfers, base);
      out_ready = 1'b1;
      wait_xfers(base + (`FIFO_RATIO + DEPTH) / `FIFO_RATIO);
      read_status(1, 0, 1, 0);
      end_test("full channel");

      for (int i = 0; i < 4; i++) begin
         apb_xfer(1'b1, BAD_ADDR[i], 8'ha5, rd, err);
         check_val("pslverr_o", int'(err), 1);
         apb_xfer(1'b0, BAD_ADDR[i], 8'h00, rd, err);
         check_val("pslverr_o", int'(err), 1);
      end
      for (int c = 0; c < `FIFO_N_CH; c++) begin
         read_status(c, 0, 1, 0);
      end
      end_test("bad address");

      ready_rand = 1'b1;
      for (int i = 0; i < N_RAND; i++) begin
         r = $random(seed);
         push_until_taken(int'(r[9:8]));
      end
      // pad every channel to whole words
      for (int c = 0; c < `FIFO_N_CH; c++) begin
         while (ref_q[c].size() % `FIFO_RATIO != 0) begin
            push_until_taken(c);
         end
      end
      ready_rand = 1'b0;
      out_ready  = 1'b1;
      while (queued_bytes() != 0) begin
         tick();
      end
      for (int c = 0; c < `FIFO_N_CH; c++) begin
         read_status(c, 0, 1, 0);
      end
      end_test("random traffic");

      out_ready = 1'b0;
      rr_on     = 1'b1;
      base      = xfers;
      for (int k = 0; k < 4; k++) begin
         for (int i = 0; i < `FIFO_RATIO; i++) begin
            push_byte(FILL_ORDER[k], byte_t'(16 * k + i), err);
            check_val("pslverr_o", int'(err), 0);
         end
      end
      out_ready = 1'b1;
      wait_xfers(base + 4);
      rr_on = 1'b0;
      check_val("last out_ch_o", int'(rr_prev), int'(ch_idx_t'(FILL_ORDER[0] - 1)));
      end_test("round robin");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + mon_errors);
      if (errors + mon_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
